// ==== Bender.yml ====
package:
  name: l1_mem_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_bus_pkg.sv
      - logic/cache_port_pkg.sv
      - logic/l1i_cache.sv
      - logic/l1d_cache.sv
      - logic/mem_arbiter.sv
      - logic/flush_sequencer.sv
      - logic/l1_mem_subsys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/mem_model.sv
      - testbench/l1_mem_subsys_tb.sv

// ==== l1_mem_subsys.f ====
+incdir+logic
logic/mem_bus_pkg.sv
logic/cache_port_pkg.sv
logic/l1i_cache.sv
logic/l1d_cache.sv
logic/mem_arbiter.sv
logic/flush_sequencer.sv
logic/l1_mem_subsys.sv
testbench/mem_model.sv
testbench/l1_mem_subsys_tb.sv

// ==== logic/cache_port_pkg.sv ====
`include "mem_defs.svh"
`default_nettype none

package cache_port_pkg;

   typedef logic [`LG_LINES-1:0] index_t;
   typedef logic [`LG_LINE_WORDS-1:0] offset_t;
   typedef logic [`ADDR_W-`LG_LINES-`LG_LINE_WORDS-3:0] tag_t;

   typedef struct packed
   {
      logic              write;
      logic [`ADDR_W-1:0] addr;
      logic [`WORD_W-1:0] data;
   } cpu_req_t;

   typedef struct packed
   {
      logic [`WORD_W-1:0] data;
   } cpu_rsp_t;

   typedef struct packed
   {
      logic [`CNT_W-1:0] accesses;
      logic [`CNT_W-1:0] hits;
   } cache_stats_t;

   typedef enum logic [2:0]
   {
      FLUSH_IDLE,
      WAIT_FOR_BOTH,
      GOT_L1D,
      GOT_L1I,
      FLUSH_DONE
   } flush_state_t;

   // l1i never enters C_WRITE
   typedef enum logic [1:0]
   {
      C_IDLE,
      C_FILL,
      C_WRITE,
      C_FLUSH
   } cache_state_t;

   typedef enum logic
   {
      REQ_L1I,
      REQ_L1D
   } requester_t;

   function automatic index_t addr_index(input logic [`ADDR_W-1:0] addr);
      return index_t'(addr >> (`LG_LINE_WORDS + 2));
   endfunction

   function automatic tag_t addr_tag(input logic [`ADDR_W-1:0] addr);
      return tag_t'(addr >> (`LG_LINES + `LG_LINE_WORDS + 2));
   endfunction

   function automatic offset_t addr_offset(input logic [`ADDR_W-1:0] addr);
      return offset_t'(addr >> 2);
   endfunction

   function automatic logic [`ADDR_W-1:0] line_addr(input logic [`ADDR_W-1:0] addr);
      return {addr[`ADDR_W-1:`LG_LINE_WORDS+2], {(`LG_LINE_WORDS+2){1'b0}}};
   endfunction

endpackage

`default_nettype wire

// ==== logic/flush_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module flush_sequencer
(
   input  wire  clk,
   input  wire  reset,
   input  wire  flush,
   input  wire  l1i_flush_complete,
   input  wire  l1d_flush_complete,
   output logic l1i_flush_req,
   output logic l1d_flush_req,
   output logic in_flush_mode,
   output logic flush_done
);
   import cache_port_pkg::*;

   flush_state_t state;
   flush_state_t next_state;

   assign in_flush_mode = (state != FLUSH_IDLE);
   assign flush_done = (state == FLUSH_DONE);

   always_comb
   begin
      next_state = state;
      case (state)
         FLUSH_IDLE:
            if (flush)
               next_state = WAIT_FOR_BOTH;
         WAIT_FOR_BOTH:
         begin
            if (l1i_flush_complete && l1d_flush_complete)
               next_state = FLUSH_DONE;
            else if (l1d_flush_complete)
               next_state = GOT_L1D;
            else if (l1i_flush_complete)
               next_state = GOT_L1I;
         end
         GOT_L1D:
            if (l1i_flush_complete)
               next_state = FLUSH_DONE;
         GOT_L1I:
            if (l1d_flush_complete)
               next_state = FLUSH_DONE;
         FLUSH_DONE:
            next_state = FLUSH_IDLE;
         default:
            next_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= FLUSH_IDLE;
         l1i_flush_req <= 1'b0;
         l1d_flush_req <= 1'b0;
      end
      else
      begin
         state <= next_state;
         l1i_flush_req <= (state == FLUSH_IDLE) && flush;   // both caches start together
         l1d_flush_req <= (state == FLUSH_IDLE) && flush;
      end
   end

endmodule

`default_nettype wire

// ==== logic/l1_mem_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_mem_subsys
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          fetch_req_valid,
   input  wire cache_port_pkg::cpu_req_t fetch_req,
   input  wire                          data_req_valid,
   input  wire cache_port_pkg::cpu_req_t data_req,
   input  wire                          flush,
   input  wire                          mem_rsp_valid,
   input  wire mem_bus_pkg::mem_rsp_t   mem_rsp,
   output logic                         fetch_rsp_valid,
   output cache_port_pkg::cpu_rsp_t     fetch_rsp,
   output logic                         data_rsp_valid,
   output cache_port_pkg::cpu_rsp_t     data_rsp,
   output logic                         in_flush_mode,
   output logic                         flush_done,
   output logic                         mem_req_valid,
   output mem_bus_pkg::mem_req_t        mem_req,
   output cache_port_pkg::cache_stats_t l1i_stats,
   output cache_port_pkg::cache_stats_t l1d_stats
);
   import cache_port_pkg::*;
   import mem_bus_pkg::*;

   logic     l1i_mem_req_valid;
   mem_req_t l1i_mem_req;
   logic     l1i_mem_rsp_valid;
   mem_rsp_t l1i_mem_rsp;
   logic     l1d_mem_req_valid;
   mem_req_t l1d_mem_req;
   logic     l1d_mem_rsp_valid;
   mem_rsp_t l1d_mem_rsp;
   logic     l1i_flush_req;
   logic     l1d_flush_req;
   logic     l1i_flush_complete;
   logic     l1d_flush_complete;

   l1i_cache icache
   (
      .clk(clk),
      .reset(reset),
      .req_valid(fetch_req_valid),
      .req(fetch_req),
      .mem_rsp_valid(l1i_mem_rsp_valid),
      .mem_rsp(l1i_mem_rsp),
      .flush_req(l1i_flush_req),
      .rsp_valid(fetch_rsp_valid),
      .rsp(fetch_rsp),
      .mem_req_valid(l1i_mem_req_valid),
      .mem_req(l1i_mem_req),
      .flush_complete(l1i_flush_complete),
      .stats(l1i_stats)
   );

   l1d_cache dcache
   (
      .clk(clk),
      .reset(reset),
      .req_valid(data_req_valid),
      .req(data_req),
      .mem_rsp_valid(l1d_mem_rsp_valid),
      .mem_rsp(l1d_mem_rsp),
      .flush_req(l1d_flush_req),
      .rsp_valid(data_rsp_valid),
      .rsp(data_rsp),
      .mem_req_valid(l1d_mem_req_valid),
      .mem_req(l1d_mem_req),
      .flush_complete(l1d_flush_complete),
      .stats(l1d_stats)
   );

   mem_arbiter arb
   (
      .clk(clk),
      .reset(reset),
      .i_req_valid(l1i_mem_req_valid),
      .i_req(l1i_mem_req),
      .d_req_valid(l1d_mem_req_valid),
      .d_req(l1d_mem_req),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp(mem_rsp),
      .i_rsp_valid(l1i_mem_rsp_valid),
      .i_rsp(l1i_mem_rsp),
      .d_rsp_valid(l1d_mem_rsp_valid),
      .d_rsp(l1d_mem_rsp),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req)
   );

   flush_sequencer flush_seq
   (
      .clk(clk),
      .reset(reset),
      .flush(flush),
      .l1i_flush_complete(l1i_flush_complete),
      .l1d_flush_complete(l1d_flush_complete),
      .l1i_flush_req(l1i_flush_req),
      .l1d_flush_req(l1d_flush_req),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done)
   );

endmodule

`default_nettype wire

// ==== logic/l1d_cache.sv ====
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module l1d_cache
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          req_valid,
   input  wire cache_port_pkg::cpu_req_t req,
   input  wire                          mem_rsp_valid,
   input  wire mem_bus_pkg::mem_rsp_t   mem_rsp,
   input  wire                          flush_req,
   output logic                         rsp_valid,
   output cache_port_pkg::cpu_rsp_t     rsp,
   output logic                         mem_req_valid,
   output mem_bus_pkg::mem_req_t        mem_req,
   output logic                         flush_complete,
   output cache_port_pkg::cache_stats_t stats
);
   import cache_port_pkg::*;
   import mem_bus_pkg::*;

   tag_t  tag_mem  [0:(1 << `LG_LINES)-1];
   line_t data_mem [0:(1 << `LG_LINES)-1];
   logic [(1 << `LG_LINES)-1:0] line_valid;

   cache_state_t state;
   logic    flush_pend;
   index_t  flush_idx;
   addr_t   req_addr;   // address of the open load miss

   index_t  idx;
   tag_t    tag;
   offset_t off;
   logic    hit;
   logic    fill_done;

   assign idx = addr_index(req.addr);
   assign tag = addr_tag(req.addr);
   assign off = addr_offset(req.addr);
   assign hit = line_valid[idx] && (tag_mem[idx] == tag);
   assign fill_done = (state == C_FILL) && mem_rsp_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= C_IDLE;
         flush_pend <= 1'b0;
         flush_idx <= '0;
         line_valid <= '0;
         rsp_valid <= 1'b0;
         mem_req_valid <= 1'b0;
         flush_complete <= 1'b0;
         stats <= '0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         mem_req_valid <= 1'b0;
         flush_complete <= 1'b0;
         if (flush_req)
            flush_pend <= 1'b1;
         case (state)
            C_IDLE:
            begin
               if (req_valid)
               begin
                  stats.accesses <= stats.accesses + 1'b1;
                  if (hit)
                     stats.hits <= stats.hits + 1'b1;
                  if (req.write)
                  begin
                     // write-through, hit or miss
                     mem_req_valid <= 1'b1;
                     state <= C_WRITE;
                  end
                  else if (hit)
                     rsp_valid <= 1'b1;
                  else
                  begin
                     mem_req_valid <= 1'b1;
                     state <= C_FILL;
                  end
               end
               else if (flush_pend || flush_req)
               begin
                  flush_pend <= 1'b0;
                  flush_idx <= '0;
                  state <= C_FLUSH;
               end
            end
            C_FILL:
            begin
               if (mem_rsp_valid)
               begin
                  line_valid[addr_index(req_addr)] <= 1'b1;
                  rsp_valid <= 1'b1;
                  state <= C_IDLE;
               end
            end
            C_WRITE:
            begin
               if (mem_rsp_valid)
               begin
                  rsp_valid <= 1'b1;   // store done
                  state <= C_IDLE;
               end
            end
            C_FLUSH:
            begin
               // nothing dirty, invalidate only
               line_valid[flush_idx] <= 1'b0;
               flush_idx <= flush_idx + 1'b1;
               if (flush_idx == index_t'(`FLUSH_LAST))
               begin
                  flush_complete <= 1'b1;
                  state <= C_IDLE;
               end
            end
            default:
               state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == C_IDLE) && req_valid)
      begin
         req_addr <= req.addr;
         rsp.data <= data_mem[idx][off*`WORD_W +: `WORD_W];
         mem_req.write <= req.write;
         mem_req.addr <= req.write ? req.addr : line_addr(req.addr);
         mem_req.data <= req.data;
         if (req.write && hit)
            data_mem[idx][off*`WORD_W +: `WORD_W] <= req.data;
      end
      if (fill_done)
      begin
         tag_mem[addr_index(req_addr)] <= addr_tag(req_addr);
         data_mem[addr_index(req_addr)] <= mem_rsp.line;
         rsp.data <= mem_rsp.line[addr_offset(req_addr)*`WORD_W +: `WORD_W];
      end
   end

endmodule

`default_nettype wire

// ==== logic/l1i_cache.sv ====
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module l1i_cache
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          req_valid,
   input  wire cache_port_pkg::cpu_req_t req,
   input  wire                          mem_rsp_valid,
   input  wire mem_bus_pkg::mem_rsp_t   mem_rsp,
   input  wire                          flush_req,
   output logic                         rsp_valid,
   output cache_port_pkg::cpu_rsp_t     rsp,
   output logic                         mem_req_valid,
   output mem_bus_pkg::mem_req_t        mem_req,
   output logic                         flush_complete,
   output cache_port_pkg::cache_stats_t stats
);
   import cache_port_pkg::*;
   import mem_bus_pkg::*;

   tag_t  tag_mem  [0:(1 << `LG_LINES)-1];
   line_t data_mem [0:(1 << `LG_LINES)-1];
   logic [(1 << `LG_LINES)-1:0] line_valid;

   cache_state_t state;
   logic    flush_pend;   // flush seen during a miss
   index_t  flush_idx;
   addr_t   req_addr;

   index_t  idx;
   tag_t    tag;
   offset_t off;
   logic    hit;
   logic    fill_done;

   assign idx = addr_index(req.addr);
   assign tag = addr_tag(req.addr);
   assign off = addr_offset(req.addr);
   assign hit = line_valid[idx] && (tag_mem[idx] == tag);
   assign fill_done = (state == C_FILL) && mem_rsp_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= C_IDLE;
         flush_pend <= 1'b0;
         flush_idx <= '0;
         line_valid <= '0;
         rsp_valid <= 1'b0;
         mem_req_valid <= 1'b0;
         flush_complete <= 1'b0;
         stats <= '0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         mem_req_valid <= 1'b0;
         flush_complete <= 1'b0;
         if (flush_req)
            flush_pend <= 1'b1;
         case (state)
            C_IDLE:
            begin
               if (req_valid)
               begin
                  stats.accesses <= stats.accesses + 1'b1;
                  if (hit)
                  begin
                     stats.hits <= stats.hits + 1'b1;
                     rsp_valid <= 1'b1;
                  end
                  else
                  begin
                     mem_req_valid <= 1'b1;
                     state <= C_FILL;
                  end
               end
               else if (flush_pend || flush_req)
               begin
                  flush_pend <= 1'b0;
                  flush_idx <= '0;
                  state <= C_FLUSH;
               end
            end
            C_FILL:
            begin
               if (mem_rsp_valid)
               begin
                  line_valid[addr_index(req_addr)] <= 1'b1;
                  rsp_valid <= 1'b1;
                  state <= C_IDLE;
               end
            end
            C_FLUSH:
            begin
               line_valid[flush_idx] <= 1'b0;   // one line per cycle
               flush_idx <= flush_idx + 1'b1;
               if (flush_idx == index_t'(`FLUSH_LAST))
               begin
                  flush_complete <= 1'b1;
                  state <= C_IDLE;
               end
            end
            default:
               state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == C_IDLE) && req_valid)
      begin
         req_addr <= req.addr;
         rsp.data <= data_mem[idx][off*`WORD_W +: `WORD_W];
         mem_req.write <= 1'b0;
         mem_req.addr <= line_addr(req.addr);
         mem_req.data <= '0;
      end
      if (fill_done)
      begin
         tag_mem[addr_index(req_addr)] <= addr_tag(req_addr);
         data_mem[addr_index(req_addr)] <= mem_rsp.line;
         rsp.data <= mem_rsp.line[addr_offset(req_addr)*`WORD_W +: `WORD_W];
      end
   end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        i_req_valid,
   input  wire mem_bus_pkg::mem_req_t i_req,
   input  wire                        d_req_valid,
   input  wire mem_bus_pkg::mem_req_t d_req,
   input  wire                        mem_rsp_valid,
   input  wire mem_bus_pkg::mem_rsp_t mem_rsp,
   output logic                       i_rsp_valid,
   output mem_bus_pkg::mem_rsp_t      i_rsp,
   output logic                       d_rsp_valid,
   output mem_bus_pkg::mem_rsp_t      d_rsp,
   output logic                       mem_req_valid,
   output mem_bus_pkg::mem_req_t      mem_req
);
   import cache_port_pkg::*;
   import mem_bus_pkg::*;

   logic       i_pend;
   logic       d_pend;
   mem_req_t   i_pend_req;
   mem_req_t   d_pend_req;
   logic       busy;    // memory transaction open
   requester_t owner;   // also the last grant
   logic       i_want;
   logic       d_want;
   logic       grant_i;
   logic       grant_d;

   assign i_want = i_req_valid || i_pend;
   assign d_want = d_req_valid || d_pend;
   assign grant_d = !busy && d_want && (!i_want || (owner == REQ_L1I));
   assign grant_i = !busy && i_want && !grant_d;

   assign i_rsp_valid = mem_rsp_valid && busy && (owner == REQ_L1I);
   assign d_rsp_valid = mem_rsp_valid && busy && (owner == REQ_L1D);
   assign i_rsp = mem_rsp;
   assign d_rsp = mem_rsp;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         i_pend <= 1'b0;
         d_pend <= 1'b0;
         busy <= 1'b0;
         owner <= REQ_L1D;   // l1i wins the first tie
         mem_req_valid <= 1'b0;
      end
      else
      begin
         mem_req_valid <= grant_i || grant_d;
         if (grant_i)
            i_pend <= 1'b0;
         else if (i_req_valid)
            i_pend <= 1'b1;
         if (grant_d)
            d_pend <= 1'b0;
         else if (d_req_valid)
            d_pend <= 1'b1;
         if (grant_i || grant_d)
         begin
            busy <= 1'b1;
            owner <= grant_d ? REQ_L1D : REQ_L1I;
         end
         else if (mem_rsp_valid)
            busy <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_req_valid)
         i_pend_req <= i_req;
      if (d_req_valid)
         d_pend_req <= d_req;
      if (grant_i)
         mem_req <= i_req_valid ? i_req : i_pend_req;
      else if (grant_d)
         mem_req <= d_req_valid ? d_req : d_pend_req;
   end

endmodule

`default_nettype wire

// ==== logic/mem_bus_pkg.sv ====
`include "mem_defs.svh"
`default_nettype none

package mem_bus_pkg;

   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [(`WORD_W << `LG_LINE_WORDS)-1:0] line_t;

   // write is a single word, read is a whole line
   typedef struct packed
   {
      logic  write;
      addr_t addr;
      word_t data;
   } mem_req_t;

   typedef struct packed
   {
      line_t line;   // empty for writes
   } mem_rsp_t;

endpackage

`default_nettype wire

// ==== logic/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`default_nettype none

`define ADDR_W        32
`define WORD_W        32
`define LG_LINE_WORDS 2   // 4 words, 128 bit lines
`define LG_LINES      4
`define CNT_W         32

// last line index of the flush walk
`define FLUSH_LAST    ((1 << `LG_LINES) - 1)

`default_nettype wire

`endif

// ==== testbench/l1_mem_subsys_tb.sv ====
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module l1_mem_subsys_tb;
   import cache_port_pkg::*;
   import mem_bus_pkg::*;

   // 200 random ops at about 12 cycles worst case, directed tests and flush on top
   localparam int max_cycles = 4000;
   localparam int mem_words = 1024;
   localparam int num_lines = 1 << `LG_LINES;
   localparam int line_words = 1 << `LG_LINE_WORDS;

   typedef struct packed
   {
      logic  is_store;
      addr_t addr;
      word_t data;
   } expect_t;

   logic         clk;
   logic         reset;
   logic         fetch_req_valid;
   cpu_req_t     fetch_req;
   logic         data_req_valid;
   cpu_req_t     data_req;
   logic         flush;
   logic         mem_rsp_valid;
   mem_rsp_t     mem_rsp;
   logic         fetch_rsp_valid;
   cpu_rsp_t     fetch_rsp;
   logic         data_rsp_valid;
   cpu_rsp_t     data_rsp;
   logic         in_flush_mode;
   logic         flush_done;
   logic         mem_req_valid;
   mem_req_t     mem_req;
   cache_stats_t l1i_stats;
   cache_stats_t l1d_stats;

   word_t        shadow_mem [0:mem_words-1];
   logic         i_valid [0:num_lines-1];
   tag_t         i_tag [0:num_lines-1];
   word_t        i_data [0:num_lines-1][0:line_words-1];   // icache may go stale
   logic         d_valid [0:num_lines-1];
   tag_t         d_tag [0:num_lines-1];
   cache_stats_t exp_i_stats;
   cache_stats_t exp_d_stats;
   expect_t      fetch_exp [$];
   expect_t      data_exp [$];
   string        test_name;
   int           data_errors;
   int           count_errors;
   int           other_errors;
   int           cycle_count = 0;
   integer       seed;

   l1_mem_subsys dut_i
   (
      .clk(clk),
      .reset(reset),
      .fetch_req_valid(fetch_req_valid),
      .fetch_req(fetch_req),
      .data_req_valid(data_req_valid),
      .data_req(data_req),
      .flush(flush),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp(mem_rsp),
      .fetch_rsp_valid(fetch_rsp_valid),
      .fetch_rsp(fetch_rsp),
      .data_rsp_valid(data_rsp_valid),
      .data_rsp(data_rsp),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .l1i_stats(l1i_stats),
      .l1d_stats(l1d_stats)
   );

   mem_model memory
   (
      .clk(clk),
      .reset(reset),
      .req_valid(mem_req_valid),
      .req(mem_req),
      .rsp_valid(mem_rsp_valid),
      .rsp(mem_rsp)
   );

   function automatic word_t image_word(input addr_t addr);
      return word_t'(addr[`ADDR_W-1:2] * 32'h9e37_79b1) ^ 32'h1357_2468;
   endfunction

   // expected word, a fetch sees the icache copy when the line is held
   function automatic word_t expected_word(input logic fetch, input addr_t addr);
      int   li;
      tag_t t;
      li = int'(addr[`LG_LINES+`LG_LINE_WORDS+1:`LG_LINE_WORDS+2]);
      t = addr[`ADDR_W-1:`LG_LINES+`LG_LINE_WORDS+2];
      if (fetch && i_valid[li] && (i_tag[li] == t))
         return i_data[li][addr[`LG_LINE_WORDS+1:2]];
      else
         return shadow_mem[addr[11:2]];
   endfunction

   task automatic finish_run();
      $display("errors: %0d data, %0d counter, %0d other", data_errors, count_errors,
               other_errors);
      if (data_errors + count_errors + other_errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   endtask

   task automatic issue_fetch(input addr_t addr);
      expect_t e;
      int      li;
      int      base;
      tag_t    t;
      logic    hit;
      li = int'(addr[`LG_LINES+`LG_LINE_WORDS+1:`LG_LINE_WORDS+2]);
      t = addr[`ADDR_W-1:`LG_LINES+`LG_LINE_WORDS+2];
      hit = i_valid[li] && (i_tag[li] == t);
      exp_i_stats.accesses = exp_i_stats.accesses + 1;
      if (hit)
         exp_i_stats.hits = exp_i_stats.hits + 1;
      else
      begin
         base = int'(addr[11:`LG_LINE_WORDS+2]) * line_words;
         i_valid[li] = 1'b1;
         i_tag[li] = t;
         for (int k = 0; k < line_words; k++)
            i_data[li][k] = shadow_mem[base + k];
      end
      e.is_store = 1'b0;
      e.addr = addr;
      e.data = expected_word(1'b1, addr);
      fetch_exp.push_back(e);
      fetch_req.write = 1'b0;
      fetch_req.addr = addr;
      fetch_req.data = '0;
      fetch_req_valid = 1'b1;
   endtask

   task automatic issue_data(input logic write, input addr_t addr, input word_t data);
      expect_t e;
      int      li;
      tag_t    t;
      logic    hit;
      li = int'(addr[`LG_LINES+`LG_LINE_WORDS+1:`LG_LINE_WORDS+2]);
      t = addr[`ADDR_W-1:`LG_LINES+`LG_LINE_WORDS+2];
      hit = d_valid[li] && (d_tag[li] == t);
      exp_d_stats.accesses = exp_d_stats.accesses + 1;
      if (hit)
         exp_d_stats.hits = exp_d_stats.hits + 1;
      if (write)
         shadow_mem[addr[11:2]] = data;   // no allocate on a miss
      else if (!hit)
      begin
         d_valid[li] = 1'b1;
         d_tag[li] = t;
      end
      e.is_store = write;
      e.addr = addr;
      e.data = write ? data : expected_word(1'b0, addr);   // store data goes to memory
      data_exp.push_back(e);
      data_req.write = write;
      data_req.addr = addr;
      data_req.data = data;
      data_req_valid = 1'b1;
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
      fetch_req_valid = 1'b0;
      data_req_valid = 1'b0;
      flush = 1'b0;
   endtask

   task automatic wait_idle();
      while (fetch_exp.size() != 0 || data_exp.size() != 0)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic fetch_once(input addr_t addr);
      issue_fetch(addr);
      step_cycle();
      wait_idle();
   endtask

   task automatic data_once(input logic write, input addr_t addr, input word_t data);
      issue_data(write, addr, data);
      step_cycle();
      wait_idle();
   endtask

   task automatic check_stats(input string which, input cache_stats_t exp,
                              input cache_stats_t act);
      if (act.accesses !== exp.accesses)
      begin
         $display("** Error [%s] %s accesses: expected %0d, actual %0d", test_name, which,
                  exp.accesses, act.accesses);
         count_errors++;
      end
      if (act.hits !== exp.hits)
      begin
         $display("** Error [%s] %s hits: expected %0d, actual %0d", test_name, which,
                  exp.hits, act.hits);
         count_errors++;
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= max_cycles)
      begin
         $display("timeout: run still going after %0d cycles", max_cycles);
         other_errors++;
         finish_run();
      end
   end

   // compares every response strobe against the queued expectation
   always @(posedge clk)
   begin
      expect_t e;
      if (mem_req_valid)
      begin
         if (mem_req.write)
         begin
            if (data_exp.size() == 0 || !data_exp[0].is_store)
            begin
               $display("memory write with no store outstanding in test %s", test_name);
               other_errors++;
            end
            else if (mem_req.addr !== data_exp[0].addr || mem_req.data !== data_exp[0].data)
            begin
               $display("** Error [%s] memory write: expected %h %h, actual %h %h", test_name,
                        data_exp[0].addr, data_exp[0].data, mem_req.addr, mem_req.data);
               data_errors++;
            end
         end
         else if (mem_req.addr[`LG_LINE_WORDS+1:0] !== '0)
         begin
            $display("memory read %h is not line aligned in test %s", mem_req.addr,
                     test_name);
            other_errors++;
         end
      end
      if (fetch_rsp_valid)
      begin
         if (fetch_exp.size() == 0)
         begin
            $display("unexpected fetch response strobe in test %s", test_name);
            other_errors++;
         end
         else
         begin
            e = fetch_exp.pop_front();
            if (fetch_rsp.data !== e.data)
            begin
               $display("** Error [%s] fetch %h: expected %h, actual %h", test_name, e.addr,
                        e.data, fetch_rsp.data);
               data_errors++;
            end
         end
      end
      if (data_rsp_valid)
      begin
         if (data_exp.size() == 0)
         begin
            $display("unexpected data response strobe in test %s", test_name);
            other_errors++;
         end
         else
         begin
            e = data_exp.pop_front();
            if (!e.is_store && (data_rsp.data !== e.data))
            begin
               $display("** Error [%s] load %h: expected %h, actual %h", test_name, e.addr,
                        e.data, data_rsp.data);
               data_errors++;
            end
         end
      end
   end

   initial
   begin
      int    kind;
      int    k;
      word_t wdata;
      seed = 79;
      reset = 1'b1;
      fetch_req_valid = 1'b0;
      fetch_req = '0;
      data_req_valid = 1'b0;
      data_req = '0;
      flush = 1'b0;
      data_errors = 0;
      count_errors = 0;
      other_errors = 0;
      exp_i_stats = '0;
      exp_d_stats = '0;
      for (int i = 0; i < mem_words; i++)
         shadow_mem[i] = image_word(addr_t'(i * 4));
      for (int l = 0; l < num_lines; l++)
      begin
         i_valid[l] = 1'b0;
         d_valid[l] = 1'b0;
      end
      test_name = "reset";
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      test_name = "after_reset";
      repeat (8)
      begin
         if (in_flush_mode !== 1'b0 || flush_done !== 1'b0 || mem_req_valid !== 1'b0)
         begin
            $display("flush or memory strobe active after reset");
            other_errors++;
         end
         step_cycle();
      end
      check_stats("l1i", exp_i_stats, l1i_stats);
      check_stats("l1d", exp_d_stats, l1d_stats);

      test_name = "icache_fill";
      fetch_once(32'h100);
      fetch_once(32'h104);
      fetch_once(32'h10c);
      check_stats("l1i", exp_i_stats, l1i_stats);

      test_name = "store_load";
      data_once(1'b1, 32'h2a4, 32'hcafe_0001);   // store miss
      data_once(1'b0, 32'h2a4, '0);
      data_once(1'b1, 32'h2a4, 32'hbeef_0002);   // store hit
      data_once(1'b0, 32'h2a4, '0);
      fetch_once(32'h2a4);
      check_stats("l1d", exp_d_stats, l1d_stats);

      test_name = "shared_port";
      issue_fetch(32'h388);
      issue_data(1'b0, 32'h3c4, '0);
      step_cycle();
      wait_idle();
      check_stats("l1i", exp_i_stats, l1i_stats);
      check_stats("l1d", exp_d_stats, l1d_stats);

      test_name = "flush";
      fetch_once(32'h104);
      issue_data(1'b0, 32'h240, '0);   // miss still open when the flush arrives
      step_cycle();
      flush = 1'b1;
      for (int l = 0; l < num_lines; l++)
      begin
         i_valid[l] = 1'b0;
         d_valid[l] = 1'b0;
      end
      step_cycle();
      while (flush_done !== 1'b1)
      begin
         if (in_flush_mode !== 1'b1)
         begin
            $display("in_flush_mode low before flush_done");
            other_errors++;
         end
         @(posedge clk);
         #1;
      end
      if (in_flush_mode !== 1'b1)
      begin
         $display("in_flush_mode low in the flush_done cycle");
         other_errors++;
      end
      step_cycle();
      if (in_flush_mode !== 1'b0 || flush_done !== 1'b0)
      begin
         $display("flush outputs still high after flush_done");
         other_errors++;
      end
      wait_idle();
      fetch_once(32'h104);
      data_once(1'b0, 32'h2a4, '0);
      data_once(1'b0, 32'h240, '0);
      check_stats("l1i", exp_i_stats, l1i_stats);
      check_stats("l1d", exp_d_stats, l1d_stats);

      test_name = "random_mix";
      for (int n = 0; n < 200; n++)
      begin
         kind = {$random(seed)} % 3;
         k = {$random(seed)} % 64;
         wdata = $random(seed);
         if (kind == 0)
            fetch_once(addr_t'(k * 20));
         else
            data_once(kind == 2, addr_t'(k * 20), wdata);
      end
      check_stats("l1i", exp_i_stats, l1i_stats);
      check_stats("l1d", exp_d_stats, l1d_stats);

      finish_run();
   end

endmodule

`default_nettype wire

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module mem_model
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        req_valid,
   input  wire mem_bus_pkg::mem_req_t req,
   output logic                       rsp_valid,
   output mem_bus_pkg::mem_rsp_t      rsp
);
   import mem_bus_pkg::*;

   localparam int depth = 1024;   // 4 KB image

   word_t    words [0:depth-1];
   integer   seed;
   logic     open;
   int       wait_cnt;
   mem_req_t cur;

   function automatic word_t image_word(input addr_t addr);
      return word_t'(addr[`ADDR_W-1:2] * 32'h9e37_79b1) ^ 32'h1357_2468;
   endfunction

   task automatic respond(input mem_req_t r);
      int base;
      base = int'(r.addr[11:2]);
      rsp = '0;
      if (r.write)
         words[base] = r.data;   // empty strobe for writes
      else
         for (int k = 0; k < (1 << `LG_LINE_WORDS); k++)
            rsp.line[k*`WORD_W +: `WORD_W] = words[base + k];
      rsp_valid = 1'b1;
   endtask

   initial
   begin
      seed = 79;
      open = 1'b0;
      wait_cnt = 0;
      rsp_valid = 1'b0;
      rsp = '0;
      for (int i = 0; i < depth; i++)
         words[i] = image_word(addr_t'(i * 4));
   end

   always @(posedge clk)
   begin
      logic     got;
      mem_req_t got_req;
      got = req_valid;
      got_req = req;
      #1;
      rsp_valid = 1'b0;
      if (reset)
         open = 1'b0;
      else
      begin
         if (open)
         begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0)
            begin
               respond(cur);
               open = 1'b0;
            end
         end
         if (got)
         begin
            cur = got_req;
            wait_cnt = 1 + ({$random(seed)} % 5);   // 2 to 6 cycles
            open = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
